// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_rv_decoder
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_decoder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
exit 1

// ==== source/decode_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_decode_defines.svh"

module decode_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      inst_valid,
    input  wire [`RV_INST_W-1:0]     inst,
    input  wire rv_decode_pkg::ctrl_t ctrl,
    input  wire [`RV_XLEN-1:0]       imm,
    output logic                     out_valid,
    output rv_decode_pkg::decoded_t  decoded
);

    logic [`RV_REG_ADDR_W-1:0] rd_field;
    logic [`RV_REG_ADDR_W-1:0] rs1_field;
    logic [`RV_REG_ADDR_W-1:0] rs2_field;
    rv_decode_pkg::decoded_t   decoded_d;

    assign rd_field  = inst[11:7];
    assign rs1_field = inst[19:15];
    assign rs2_field = inst[24:20];

    // illegal and ebreak leave a clean record with one flag set
    always_comb begin
        decoded_d = '0;
        if (ctrl.illegal) begin
            decoded_d.ctrl.illegal = 1'b1;
        end else if (ctrl.ebreak) begin
            decoded_d.ctrl.ebreak = 1'b1;
        end else begin
            decoded_d.ctrl = ctrl;
            decoded_d.rs1  = ctrl.use_rs1 ? rs1_field : '0;
            decoded_d.rs2  = ctrl.use_rs2 ? rs2_field : '0;
            decoded_d.rd   = ctrl.reg_wen ? rd_field : '0; // no rd for stores, branches
            decoded_d.imm  = imm;
        end
    end

    // one pipeline register, record follows every edge
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            decoded   <= '0;
        end else begin
            out_valid <= inst_valid;
            decoded   <= decoded_d; // don't care while out_valid low
        end
    end

endmodule

`default_nettype wire

// ==== source/imm_generator.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_decode_defines.svh"

module imm_generator (
    input  wire  [`RV_INST_W-1:0] inst,
    output logic [`RV_XLEN-1:0]   imm
);

    logic [6:0] opcode;
    logic       is_shift; // funct3 001 or 101

    assign opcode   = inst[6:0];
    assign is_shift = (inst[13:12] == 2'b01);

    always_comb begin
        imm = '0;
        case (opcode)
            `RV_OPC_OP_IMM: begin
                if (is_shift) begin
                    imm = {{(`RV_XLEN-6){1'b0}}, inst[25:20]}; // 6-bit shamt
                end else begin
                    imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
                end
            end
            `RV_OPC_OP_IMM_32: begin
                if (is_shift) begin
                    imm = {{(`RV_XLEN-5){1'b0}}, inst[24:20]};
                end else begin
                    imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
                end
            end
            `RV_OPC_LOAD, `RV_OPC_JALR: begin
                imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
            end
            `RV_OPC_STORE: begin
                imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            `RV_OPC_BRANCH: begin // 13-bit offset, lsb zero
                imm = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7],
                       inst[30:25], inst[11:8], 1'b0};
            end
            `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                imm = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            end
            `RV_OPC_JAL: begin // 21-bit offset
                imm = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12],
                       inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/inst_classifier.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_decode_defines.svh"

module inst_classifier (
    input  wire [`RV_INST_W-1:0] inst,
    output rv_decode_pkg::ctrl_t ctrl
);

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6; // upper bits above a 6-bit shamt

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26];

    always_comb begin
        ctrl = '0;
        case (opcode)
            `RV_OPC_OP: begin
                ctrl.reg_wen = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
                ctrl.alu_src = rv_decode_pkg::REG;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   ctrl.alu_op = rv_decode_pkg::ADD;
                    {F7_BASE, 3'b001}:   ctrl.alu_op = rv_decode_pkg::SLL;
                    {F7_BASE, 3'b010}:   ctrl.alu_op = rv_decode_pkg::SLT;
                    {F7_BASE, 3'b011}:   ctrl.alu_op = rv_decode_pkg::SLTU;
                    {F7_BASE, 3'b100}:   ctrl.alu_op = rv_decode_pkg::XOR;
                    {F7_BASE, 3'b101}:   ctrl.alu_op = rv_decode_pkg::SRL;
                    {F7_BASE, 3'b110}:   ctrl.alu_op = rv_decode_pkg::OR;
                    {F7_BASE, 3'b111}:   ctrl.alu_op = rv_decode_pkg::AND;
                    {F7_ALT, 3'b000}:    ctrl.alu_op = rv_decode_pkg::SUB;
                    {F7_ALT, 3'b101}:    ctrl.alu_op = rv_decode_pkg::SRA;
                    {F7_MULDIV, 3'b000}: ctrl.alu_op = rv_decode_pkg::MUL;
                    {F7_MULDIV, 3'b101}: ctrl.alu_op = rv_decode_pkg::DIVU;
                    {F7_MULDIV, 3'b111}: ctrl.alu_op = rv_decode_pkg::REMU;
                    default:             ctrl.illegal = 1'b1;
                endcase
            end
            `RV_OPC_OP_IMM: begin
                ctrl.reg_wen = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.alu_src = rv_decode_pkg::IMM;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_decode_pkg::ADD;
                    3'b010: ctrl.alu_op = rv_decode_pkg::SLT;
                    3'b011: ctrl.alu_op = rv_decode_pkg::SLTU;
                    3'b100: ctrl.alu_op = rv_decode_pkg::XOR;
                    3'b110: ctrl.alu_op = rv_decode_pkg::OR;
                    3'b111: ctrl.alu_op = rv_decode_pkg::AND;
                    3'b001: begin
                        ctrl.alu_op = rv_decode_pkg::SLL;
                        if (funct6 != 6'b000000) begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                    default: begin // 101, srli or srai
                        if (funct6 == 6'b000000) begin
                            ctrl.alu_op = rv_decode_pkg::SRL;
                        end else if (funct6 == 6'b010000) begin
                            ctrl.alu_op = rv_decode_pkg::SRA;
                        end else begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                endcase
            end
            `RV_OPC_OP_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
                ctrl.alu_src = rv_decode_pkg::REG;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   ctrl.alu_op = rv_decode_pkg::ADD;
                    {F7_BASE, 3'b001}:   ctrl.alu_op = rv_decode_pkg::SLL;
                    {F7_BASE, 3'b101}:   ctrl.alu_op = rv_decode_pkg::SRL;
                    {F7_ALT, 3'b000}:    ctrl.alu_op = rv_decode_pkg::SUB;
                    {F7_ALT, 3'b101}:    ctrl.alu_op = rv_decode_pkg::SRA;
                    {F7_MULDIV, 3'b000}: ctrl.alu_op = rv_decode_pkg::MUL;
                    {F7_MULDIV, 3'b100}: ctrl.alu_op = rv_decode_pkg::DIV;
                    {F7_MULDIV, 3'b110}: ctrl.alu_op = rv_decode_pkg::REM;
                    default:             ctrl.illegal = 1'b1;
                endcase
            end
            `RV_OPC_OP_IMM_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.alu_src = rv_decode_pkg::IMM;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_decode_pkg::ADD;
                    3'b001: begin
                        ctrl.alu_op = rv_decode_pkg::SLL;
                        if (funct7 != F7_BASE) begin // bit 25 must be clear too
                            ctrl.illegal = 1'b1;
                        end
                    end
                    3'b101: begin
                        if (funct7 == F7_BASE) begin
                            ctrl.alu_op = rv_decode_pkg::SRL;
                        end else if (funct7 == F7_ALT) begin
                            ctrl.alu_op = rv_decode_pkg::SRA;
                        end else begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `RV_OPC_LOAD: begin
                ctrl.reg_wen      = 1'b1;
                ctrl.use_rs1      = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.alu_src      = rv_decode_pkg::IMM; // rs1 + offset
                ctrl.mem_size     = rv_decode_pkg::mem_size_t'(funct3[1:0]);
                ctrl.mem_unsigned = funct3[2];
                if (funct3 == 3'b111) begin
                    ctrl.illegal = 1'b1;
                end
            end
            `RV_OPC_STORE: begin
                ctrl.use_rs1   = 1'b1;
                ctrl.use_rs2   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = rv_decode_pkg::IMM;
                case (funct3)
                    3'b000: begin
                        ctrl.mem_size = rv_decode_pkg::BYTE;
                        ctrl.wmask    = 8'h01;
                    end
                    3'b001: begin
                        ctrl.mem_size = rv_decode_pkg::HALF;
                        ctrl.wmask    = 8'h03;
                    end
                    3'b010: begin
                        ctrl.mem_size = rv_decode_pkg::WORD;
                        ctrl.wmask    = 8'h0F;
                    end
                    3'b011: begin
                        ctrl.mem_size = rv_decode_pkg::DOUBLE;
                        ctrl.wmask    = 8'hFF;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `RV_OPC_BRANCH: begin
                ctrl.branch  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
                ctrl.alu_op  = rv_decode_pkg::SUB; // compare rs1 against rs2
                ctrl.alu_src = rv_decode_pkg::REG;
                case (funct3)
                    3'b000:  ctrl.branch_cond = rv_decode_pkg::EQ;
                    3'b001:  ctrl.branch_cond = rv_decode_pkg::NE;
                    3'b100:  ctrl.branch_cond = rv_decode_pkg::LT;
                    3'b101:  ctrl.branch_cond = rv_decode_pkg::GE;
                    3'b110:  ctrl.branch_cond = rv_decode_pkg::LTU;
                    3'b111:  ctrl.branch_cond = rv_decode_pkg::GEU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `RV_OPC_JAL: begin
                ctrl.jump    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = rv_decode_pkg::PC_PLUS4;
            end
            `RV_OPC_JALR: begin
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.alu_src = rv_decode_pkg::PC_PLUS4;
                if (funct3 != 3'b000) begin
                    ctrl.illegal = 1'b1;
                end
            end
            `RV_OPC_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = rv_decode_pkg::IMM; // x0 + imm
            end
            `RV_OPC_AUIPC: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = rv_decode_pkg::PC_IMM;
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // exact word only, other SYSTEM encodings stay illegal
        if (inst == `RV_INST_EBREAK) begin
            ctrl        = '0;
            ctrl.ebreak = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_decode_defines.svh ====
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// datapath and instruction widths
`define RV_XLEN         64
`define RV_INST_W       32
`define RV_REG_ADDR_W   5

// major opcodes, inst[6:0]
`define RV_OPC_OP         7'b0110011
`define RV_OPC_OP_IMM     7'b0010011
`define RV_OPC_OP_32      7'b0111011
`define RV_OPC_OP_IMM_32  7'b0011011
`define RV_OPC_LOAD       7'b0000011
`define RV_OPC_STORE      7'b0100011
`define RV_OPC_BRANCH     7'b1100011
`define RV_OPC_JAL        7'b1101111
`define RV_OPC_JALR       7'b1100111
`define RV_OPC_LUI        7'b0110111
`define RV_OPC_AUIPC      7'b0010111

// ebreak is matched on the whole word
`define RV_INST_EBREAK    32'h0010_0073

`endif

// ==== source/rv_decode_pkg.sv ====
`default_nettype none

`include "rv_decode_defines.svh"

package rv_decode_pkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        MUL  = 4'd10,
        DIV  = 4'd11,
        DIVU = 4'd12,
        REM  = 4'd13,
        REMU = 4'd14
    } alu_op_t;

    // second operand / base select
    typedef enum logic [1:0] {
        REG      = 2'd0, // rs2
        IMM      = 2'd1,
        PC_IMM   = 2'd2, // auipc
        PC_PLUS4 = 2'd3  // link value for jal, jalr
    } alu_src_t;

    // encoded like the branch funct3
    typedef enum logic [2:0] {
        EQ  = 3'b000,
        NE  = 3'b001,
        LT  = 3'b100,
        GE  = 3'b101,
        LTU = 3'b110,
        GEU = 3'b111
    } branch_cond_t;

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_t;

    typedef struct packed {
        alu_op_t      alu_op;
        alu_src_t     alu_src;
        logic         branch;
        branch_cond_t branch_cond;
        logic         jump;
        logic         jalr;
        logic         reg_wen;
        logic         word_op;   // 32-bit op, result sign-extended
        logic         mem_read;
        logic         mem_write;
        mem_size_t    mem_size;
        logic         mem_unsigned;
        logic [7:0]   wmask;     // byte lanes of a store
        logic         use_rs1;
        logic         use_rs2;
        logic         illegal;
        logic         ebreak;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_XLEN-1:0]       imm;
    } decoded_t;

endpackage

`default_nettype wire

// ==== source/rv_decoder_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_decode_defines.svh"

module rv_decoder_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     inst_valid,
    input  wire [`RV_INST_W-1:0]    inst,
    output logic                    out_valid,
    output rv_decode_pkg::decoded_t decoded
);

    rv_decode_pkg::ctrl_t ctrl;
    logic [`RV_XLEN-1:0]  imm;

    // classifier and immediate run in parallel on the same word
    inst_classifier classifier_i (
        .inst (inst),
        .ctrl (ctrl)
    );

    imm_generator imm_gen_i (
        .inst (inst),
        .imm  (imm)
    );

    decode_stage stage_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ctrl       (ctrl),
        .imm        (imm),
        .out_valid  (out_valid),
        .decoded    (decoded)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/rv_decode_pkg.sv
source/inst_classifier.sv
source/imm_generator.sv
source/decode_stage.sv
source/rv_decoder_top.sv
tests/tb_clock_gen.sv
tests/tb_rv_decoder.sv

// ==== tests/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on a rising edge, so reset spans whole cycles
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_rv_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_decode_defines.svh"

module tb_rv_decoder;

    localparam int STIM_CYCLES = 620; // all tests back to back, plus drain cycles
    localparam int MAX_CYCLES  = STIM_CYCLES * 3 / 2;

    logic                    clk;
    logic                    reset;
    logic                    inst_valid;
    logic [`RV_INST_W-1:0]   inst;
    logic                    out_valid;
    rv_decode_pkg::decoded_t decoded;

    rv_decode_pkg::decoded_t exp_q[$];
    logic [`RV_INST_W-1:0]   word_q[$];
    rv_decode_pkg::decoded_t exp_rec;
    logic [`RV_INST_W-1:0]   exp_word;
    int                      checks = 0;
    int                      errors = 0;
    int                      test_mark = 0;
    int                      cycles = 0;
    logic                    compare_on = 1'b0;
    logic [6:0]              opcodes [11] = '{`RV_OPC_OP, `RV_OPC_OP_32, `RV_OPC_OP_IMM,
        `RV_OPC_OP_IMM_32, `RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_BRANCH, `RV_OPC_JAL,
        `RV_OPC_JALR, `RV_OPC_LUI, `RV_OPC_AUIPC};

    tb_clock_gen clock_i (
        .clk   (clk),
        .reset (reset)
    );

    rv_decoder_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_valid  (out_valid),
        .decoded    (decoded)
    );

    function automatic rv_decode_pkg::alu_op_t funct3_op(input logic [2:0] f3, input logic m);
        case ({m, f3})
            4'h0:    return rv_decode_pkg::ADD;
            4'h1:    return rv_decode_pkg::SLL;
            4'h2:    return rv_decode_pkg::SLT;
            4'h3:    return rv_decode_pkg::SLTU;
            4'h4:    return rv_decode_pkg::XOR;
            4'h5:    return rv_decode_pkg::SRL;
            4'h6:    return rv_decode_pkg::OR;
            4'h7:    return rv_decode_pkg::AND;
            4'h8:    return rv_decode_pkg::MUL;
            4'hC:    return rv_decode_pkg::DIV;
            4'hD:    return rv_decode_pkg::DIVU;
            4'hE:    return rv_decode_pkg::REM;
            4'hF:    return rv_decode_pkg::REMU;
            default: return rv_decode_pkg::ADD;
        endcase
    endfunction

    function automatic rv_decode_pkg::decoded_t expected_decode(input logic [31:0] w);
        rv_decode_pkg::decoded_t d;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] hi;
        logic       word;
        logic       bad;
        op   = w[6:0];
        f3   = w[14:12];
        f7   = w[31:25];
        word = op inside {`RV_OPC_OP_32, `RV_OPC_OP_IMM_32};
        hi   = word ? f7 : {w[31:26], 1'b0}; // shamt[5] is no funct bit in rv64
        bad  = 1'b0;
        d    = '0;
        d.ctrl.reg_wen   = !(op inside {`RV_OPC_STORE, `RV_OPC_BRANCH});
        d.ctrl.use_rs1   = !(op inside {`RV_OPC_JAL, `RV_OPC_LUI, `RV_OPC_AUIPC});
        d.ctrl.use_rs2   = op inside {`RV_OPC_OP, `RV_OPC_OP_32, `RV_OPC_STORE, `RV_OPC_BRANCH};
        d.ctrl.word_op   = word;
        d.ctrl.mem_read  = (op == `RV_OPC_LOAD);
        d.ctrl.mem_write = (op == `RV_OPC_STORE);
        d.ctrl.branch    = (op == `RV_OPC_BRANCH);
        d.ctrl.jump      = op inside {`RV_OPC_JAL, `RV_OPC_JALR};
        d.ctrl.jalr      = (op == `RV_OPC_JALR);
        if (d.ctrl.jump) begin
            d.ctrl.alu_src = rv_decode_pkg::PC_PLUS4;
        end else if (op == `RV_OPC_AUIPC) begin
            d.ctrl.alu_src = rv_decode_pkg::PC_IMM;
        end else if (!d.ctrl.use_rs2 || d.ctrl.mem_write) begin
            d.ctrl.alu_src = rv_decode_pkg::IMM;
        end
        case (op)
            `RV_OPC_OP, `RV_OPC_OP_32: begin
                if (f7 == 7'h00 && (!word || f3 inside {3'd0, 3'd1, 3'd5})) begin
                    d.ctrl.alu_op = funct3_op(f3, 1'b0);
                end else if (f7 == 7'h20 && f3 inside {3'd0, 3'd5}) begin
                    d.ctrl.alu_op = (f3 == 3'd0) ? rv_decode_pkg::SUB : rv_decode_pkg::SRA;
                end else if (f7 == 7'h01 && (word ? f3 inside {3'd0, 3'd4, 3'd6}
                                                  : f3 inside {3'd0, 3'd5, 3'd7})) begin
                    d.ctrl.alu_op = funct3_op(f3, 1'b1);
                end else begin
                    bad = 1'b1;
                end
            end
            `RV_OPC_OP_IMM, `RV_OPC_OP_IMM_32: begin
                d.imm = {{52{w[31]}}, w[31:20]};
                d.ctrl.alu_op = funct3_op(f3, 1'b0);
                bad = word && !(f3 inside {3'd0, 3'd1, 3'd5});
                if (f3 == 3'd1 || f3 == 3'd5) begin // shamt forms
                    d.imm = word ? {59'd0, w[24:20]} : {58'd0, w[25:20]};
                    bad   = !(hi == 7'h00 || (hi == 7'h20 && f3 == 3'd5));
                    if (hi == 7'h20) begin
                        d.ctrl.alu_op = rv_decode_pkg::SRA;
                    end
                end
            end
            `RV_OPC_LOAD: begin
                d.imm = {{52{w[31]}}, w[31:20]};
                d.ctrl.mem_size     = rv_decode_pkg::mem_size_t'(f3[1:0]);
                d.ctrl.mem_unsigned = f3[2];
                bad = (f3 == 3'd7);
            end
            `RV_OPC_STORE: begin
                d.imm = {{52{w[31]}}, w[31:25], w[11:7]};
                d.ctrl.mem_size = rv_decode_pkg::mem_size_t'(f3[1:0]);
                d.ctrl.wmask    = 8'((16'd1 << (5'd1 << f3[1:0])) - 16'd1); // 2**size lanes
                bad = f3[2];
            end
            `RV_OPC_BRANCH: begin
                d.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                d.ctrl.alu_op      = rv_decode_pkg::SUB; // compare by subtracting
                d.ctrl.branch_cond = rv_decode_pkg::branch_cond_t'(f3);
                bad = f3 inside {3'd2, 3'd3};
            end
            `RV_OPC_JAL: d.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            `RV_OPC_JALR: begin
                d.imm = {{52{w[31]}}, w[31:20]};
                bad = (f3 != 3'd0);
            end
            `RV_OPC_LUI, `RV_OPC_AUIPC: d.imm = {{32{w[31]}}, w[31:12], 12'd0};
            default: bad = 1'b1;
        endcase
        if (w == `RV_INST_EBREAK) begin
            d = '0;
            d.ctrl.ebreak = 1'b1;
        end else if (bad) begin
            d = '0;
            d.ctrl.illegal = 1'b1;
        end else begin
            d.rd  = d.ctrl.reg_wen ? w[11:7] : 5'd0;
            d.rs1 = d.ctrl.use_rs1 ? w[19:15] : 5'd0;
            d.rs2 = d.ctrl.use_rs2 ? w[24:20] : 5'd0;
        end
        return d;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [6:0] f7);
        return {f7, 5'($urandom()), 5'($urandom()), f3, 5'($urandom()), opc};
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input logic [31:0] w);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: inst %h field %s got %h expected %h", $time, w, name, got, exp);
        end
    endtask

    task automatic drive(input logic [31:0] w, input logic v);
        @(negedge clk);
        inst       <= w;
        inst_valid <= v;
        if (v) begin
            exp_q.push_back(expected_decode(w));
            word_q.push_back(w);
        end
    endtask

    task automatic finish_test(input string name);
        drive(32'h0, 1'b0);
        while (exp_q.size() != 0) @(negedge clk);
        $display("test %-8s done, %0d errors", name, errors - test_mark);
        test_mark = errors;
    endtask

    // mid-cycle, registered outputs are settled
    always @(negedge clk) begin
        checks++;
        if (!compare_on) begin
            if (cycles != 0 && (out_valid !== 1'b0 || decoded !== '0)) begin // no edge yet at 0
                errors++;
                $display("[ERROR] %0t: out_valid %b decoded %h, expected zero in reset", $time,
                         out_valid, decoded);
            end
        end else if (out_valid !== inst_valid) begin // inst_valid here is last cycle's
            errors++;
            $display("[ERROR] %0t: out_valid %b expected %b", $time, out_valid, inst_valid);
        end else if (out_valid) begin
            exp_rec  = exp_q.pop_front();
            exp_word = word_q.pop_front();
            check_field("ctrl", 64'(decoded.ctrl), 64'(exp_rec.ctrl), exp_word);
            check_field("rd", 64'(decoded.rd), 64'(exp_rec.rd), exp_word);
            check_field("rs1", 64'(decoded.rs1), 64'(exp_rec.rs1), exp_word);
            check_field("rs2", 64'(decoded.rs2), 64'(exp_rec.rs2), exp_word);
            check_field("imm", decoded.imm, exp_rec.imm, exp_word);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        logic [31:0] stim_word;
        void'($urandom(60));
        inst       <= '0;
        inst_valid <= 1'b0;
        @(negedge reset);
        @(negedge clk);
        compare_on <= 1'b1; // one more zero check on this edge
        finish_test("reset");

        for (int o = 0; o < 2; o++) begin
            for (int k = 0; k < 24; k++) begin
                drive(r_word(o != 0 ? `RV_OPC_OP_32 : `RV_OPC_OP, 3'(k),
                             (k < 8) ? 7'h00 : (k < 16) ? 7'h20 : 7'h01), 1'b1);
            end
        end
        finish_test("alu");

        for (int i = 2; i < 11; i++) begin
            for (int k = 0; k < 8; k++) begin
                stim_word      = $urandom();
                stim_word[6:0] = opcodes[i];
                drive(stim_word, 1'b1);
            end
        end
        for (int k = 0; k < 16; k++) begin // legal shift immediates only
            stim_word          = $urandom();
            stim_word[6:0]     = k[0] ? `RV_OPC_OP_IMM_32 : `RV_OPC_OP_IMM;
            stim_word[14:12]   = k[1] ? 3'd5 : 3'd1;
            stim_word[31:26]   = {1'b0, k[2] & k[1], 4'b0000};
            if (k[0]) begin
                stim_word[25] = 1'b0;
            end
            drive(stim_word, 1'b1);
        end
        finish_test("imm");

        for (int k = 0; k < 8; k++) begin
            drive(r_word(`RV_OPC_LOAD, 3'(k), 7'($urandom())), 1'b1);
            drive(r_word(`RV_OPC_STORE, 3'(k), 7'($urandom())), 1'b1);
            drive(r_word(`RV_OPC_BRANCH, 3'(k), 7'($urandom())), 1'b1);
        end
        drive(r_word(`RV_OPC_JAL, 3'($urandom()), 7'($urandom())), 1'b1);
        drive(r_word(`RV_OPC_JALR, 3'd0, 7'($urandom())), 1'b1);
        drive(r_word(`RV_OPC_LUI, 3'($urandom()), 7'($urandom())), 1'b1);
        drive(r_word(`RV_OPC_AUIPC, 3'($urandom()), 7'($urandom())), 1'b1);
        finish_test("mem_ctl");

        repeat (200) drive($urandom(), 1'b1);
        for (int k = 0; k < 32; k++) begin // funct7 bit 1 set is never a kept encoding
            drive(r_word(k[0] ? `RV_OPC_OP_32 : `RV_OPC_OP, 3'($urandom()),
                         7'($urandom()) | 7'h02), 1'b1);
        end
        drive(`RV_INST_EBREAK, 1'b1);
        drive(32'h0000_0073, 1'b1); // ecall
        drive(`RV_INST_EBREAK | 32'h0000_0080, 1'b1);
        finish_test("illegal");

        repeat (200) begin
            stim_word      = $urandom();
            stim_word[6:0] = opcodes[4'($urandom() % 11)];
            drive(stim_word, ($urandom() % 4) != 0);
        end
        finish_test("stream");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
